/* src/dcache_pkg.sv */
// Widths and encodings shared by the data cache blocks
// Addresses are byte addresses, lines are a single doubleword

package dcache_pkg;

  localparam int PADDR_WIDTH = 16;
  localparam int DWORD_WIDTH = 64;

  // Physical byte address
  typedef logic [PADDR_WIDTH-1:0] paddr_t;

  // One doubleword, also one cache line
  typedef logic [DWORD_WIDTH-1:0] dword_t;

  // Byte enables toward memory
  typedef logic [DWORD_WIDTH/8-1:0] strb_t;

  // Request opcodes, lw is sign-extended on return
  typedef enum logic [1:0]
  {
    e_op_ld = 2'b00,
    e_op_lw = 2'b01,
    e_op_sd = 2'b10,
    e_op_sw = 2'b11
  } dcache_op_e;

  typedef enum logic
  {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } mem_op_e;

  // Miss engine states
  typedef enum logic [1:0]
  {
    e_idle  = 2'b00,
    e_drain = 2'b01,
    e_read  = 2'b10,
    e_wait  = 2'b11
  } engine_state_e;

endpackage

/* src/replay_queue.sv */
// Requests stay in the queue until committed; replay rewinds issue to the oldest one
// Commit and replay are never asserted together

`timescale 1ns/1ps

module replay_queue
  #(parameter int queue_els_p = 8)
  (input  logic                    clk_i
  ,input  logic                    rst_n_i

  ,input  logic                    enq_v_i
  ,input  dcache_pkg::dcache_op_e  enq_op_i
  ,input  dcache_pkg::paddr_t      enq_addr_i
  ,input  dcache_pkg::dword_t      enq_data_i
  ,output logic                    enq_ready_o

  ,output logic                    issue_v_o
  ,output dcache_pkg::dcache_op_e  issue_op_o
  ,output dcache_pkg::paddr_t      issue_addr_o
  ,output dcache_pkg::dword_t      issue_data_o
  ,input  logic                    issue_yumi_i

  ,input  logic                    commit_i
  ,input  logic                    replay_i
  );

  localparam int ptr_w = (queue_els_p > 1) ? $clog2(queue_els_p) : 1;
  localparam int cnt_w = $clog2(queue_els_p + 1);

  dcache_pkg::dcache_op_e op_mem   [queue_els_p];
  dcache_pkg::paddr_t     addr_mem [queue_els_p];
  dcache_pkg::dword_t     data_mem [queue_els_p];

  logic [ptr_w-1:0] wr_ptr_r;
  logic [ptr_w-1:0] iss_ptr_r;
  logic [ptr_w-1:0] cmt_ptr_r;

  // Entries not yet committed, and of those the ones already issued
  logic [cnt_w-1:0] cnt_r;
  logic [cnt_w-1:0] iss_cnt_r;

  logic enq;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(queue_els_p - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  assign enq_ready_o = (cnt_r != cnt_w'(queue_els_p));
  assign enq         = enq_v_i & enq_ready_o;

  assign issue_v_o    = (iss_cnt_r != cnt_r);
  assign issue_op_o   = op_mem[iss_ptr_r];
  assign issue_addr_o = addr_mem[iss_ptr_r];
  assign issue_data_o = data_mem[iss_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      op_mem[wr_ptr_r]   <= enq_op_i;
      addr_mem[wr_ptr_r] <= enq_addr_i;
      data_mem[wr_ptr_r] <= enq_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_r  <= '0;
      iss_ptr_r <= '0;
      cmt_ptr_r <= '0;
      cnt_r     <= '0;
      iss_cnt_r <= '0;
    end
    else
    begin
      if (enq)
        wr_ptr_r <= next_ptr(wr_ptr_r);

      // Rewind to the oldest uncommitted entry
      if (replay_i)
      begin
        iss_ptr_r <= cmt_ptr_r;
        iss_cnt_r <= '0;
      end
      else
      begin
        if (issue_yumi_i)
          iss_ptr_r <= next_ptr(iss_ptr_r);
        iss_cnt_r <= iss_cnt_r + cnt_w'(issue_yumi_i) - cnt_w'(commit_i);
      end

      if (commit_i)
        cmt_ptr_r <= next_ptr(cmt_ptr_r);

      cnt_r <= cnt_r + cnt_w'(enq) - cnt_w'(commit_i);
    end
  end

endmodule

/* src/dcache_pipe.sv */
// Direct-mapped, write-through, no allocate on store miss; one doubleword per line
// A request that cannot finish in stage 2 is replayed together with everything behind it

`timescale 1ns/1ps

module dcache_pipe
  #(parameter int sets_p = 16)
  (input  logic                    clk_i
  ,input  logic                    rst_n_i

  ,input  logic                    issue_v_i
  ,input  dcache_pkg::dcache_op_e  issue_op_i
  ,input  dcache_pkg::paddr_t      issue_addr_i
  ,input  dcache_pkg::dword_t      issue_data_i
  ,output logic                    issue_yumi_o
  ,output logic                    commit_o
  ,output logic                    replay_o

  ,output logic                    resp_v_o
  ,output dcache_pkg::dword_t      resp_data_o

  ,output logic                    miss_v_o
  ,input  logic                    miss_ready_i
  ,output dcache_pkg::paddr_t      miss_addr_o

  ,output logic                    store_v_o
  ,input  logic                    store_ready_i
  ,output dcache_pkg::paddr_t      store_addr_o
  ,output dcache_pkg::dword_t      store_data_o
  ,output dcache_pkg::strb_t       store_strb_o

  ,input  logic                    fill_v_i
  ,input  dcache_pkg::paddr_t      fill_addr_i
  ,input  dcache_pkg::dword_t      fill_data_i
  );

  localparam int idx_w = (sets_p > 1) ? $clog2(sets_p) : 1;
  localparam int tag_w = dcache_pkg::PADDR_WIDTH - 3 - idx_w;

  logic                  valid_mem [sets_p];
  logic [tag_w-1:0]      tag_mem   [sets_p];
  dcache_pkg::dword_t    data_mem  [sets_p];

  // Shared write port for fills and store hits
  logic                  wr_v;
  logic [idx_w-1:0]      wr_idx;
  logic [tag_w-1:0]      wr_tag;
  dcache_pkg::dword_t    wr_data;

  logic [idx_w-1:0]      s0_idx;

  logic                  s1_v;
  dcache_pkg::dcache_op_e s1_op;
  dcache_pkg::paddr_t    s1_addr;
  dcache_pkg::dword_t    s1_data;
  logic                  s1_line_valid;
  logic [tag_w-1:0]      s1_line_tag;
  dcache_pkg::dword_t    s1_line;
  logic                  s1_fwd;
  logic                  s1_hit;
  dcache_pkg::dword_t    s1_line_fwd;

  logic                  s2_v;
  dcache_pkg::dcache_op_e s2_op;
  dcache_pkg::paddr_t    s2_addr;
  dcache_pkg::dword_t    s2_data;
  logic                  s2_hit;
  dcache_pkg::dword_t    s2_line;
  logic                  s2_is_store;
  logic                  s2_done;
  logic [31:0]           s2_word;
  dcache_pkg::dword_t    s2_load_data;
  dcache_pkg::dword_t    s2_store_line;

  logic                  miss_pending_r;
  logic                  miss_sent_r;
  dcache_pkg::paddr_t    miss_addr_r;

  // Stage 0: array read, taking a same-cycle write first
  assign s0_idx       = issue_addr_i[3 +: idx_w];
  assign issue_yumi_o = issue_v_i & ~miss_pending_r & ~replay_o;

  always_ff @(posedge clk_i)
  begin
    if (wr_v)
    begin
      tag_mem[wr_idx]  <= wr_tag;
      data_mem[wr_idx] <= wr_data;
    end
    s1_op   <= issue_op_i;
    s1_addr <= issue_addr_i;
    s1_data <= issue_data_i;
    if (wr_v && wr_idx == s0_idx)
    begin
      s1_line_valid <= 1'b1;
      s1_line_tag   <= wr_tag;
      s1_line       <= wr_data;
    end
    else
    begin
      s1_line_valid <= valid_mem[s0_idx];
      s1_line_tag   <= tag_mem[s0_idx];
      s1_line       <= data_mem[s0_idx];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 0; i < sets_p; i++)
        valid_mem[i] <= 1'b0;
    end
    else if (wr_v)
      valid_mem[wr_idx] <= 1'b1;
  end

  // Stage 1: tag compare, forward the line written by the older request
  assign s1_fwd      = wr_v & (wr_idx == s1_addr[3 +: idx_w]);
  assign s1_line_fwd = s1_fwd ? wr_data : s1_line;
  assign s1_hit      = (s1_fwd | s1_line_valid)
                     & ((s1_fwd ? wr_tag : s1_line_tag)
                        == s1_addr[dcache_pkg::PADDR_WIDTH-1 -: tag_w]);

  always_ff @(posedge clk_i)
  begin
    s2_op   <= s1_op;
    s2_addr <= s1_addr;
    s2_data <= s1_data;
    s2_hit  <= s1_hit;
    s2_line <= s1_line_fwd;
  end

  // Stage 2: store merge, load select, completion check
  assign s2_is_store = (s2_op == dcache_pkg::e_op_sd) | (s2_op == dcache_pkg::e_op_sw);
  assign s2_word     = s2_addr[2] ? s2_line[63:32] : s2_line[31:0];

  always_comb
  begin
    s2_store_line = s2_line;
    if (s2_op == dcache_pkg::e_op_sd)
      s2_store_line = s2_data;
    else if (s2_addr[2])
      s2_store_line[63:32] = s2_data[31:0];
    else
      s2_store_line[31:0] = s2_data[31:0];
  end

  assign s2_load_data = (s2_op == dcache_pkg::e_op_lw) ? {{32{s2_word[31]}}, s2_word} : s2_line;

  assign store_v_o    = s2_v & s2_is_store;
  assign store_addr_o = s2_addr;
  assign store_data_o = (s2_op == dcache_pkg::e_op_sd) ? s2_data : {2{s2_data[31:0]}};
  assign store_strb_o = (s2_op == dcache_pkg::e_op_sd) ? 8'hff
                      : (s2_addr[2] ? 8'hf0 : 8'h0f);

  assign s2_done     = s2_v & (s2_is_store ? store_ready_i : s2_hit);
  assign commit_o    = s2_done;
  assign replay_o    = s2_v & ~s2_done;
  assign resp_v_o    = s2_done;
  assign resp_data_o = s2_is_store ? '0 : s2_load_data;

  // Fill has priority, the pipe is empty while a miss is pending
  assign wr_v    = fill_v_i | (s2_done & s2_is_store & s2_hit);
  assign wr_idx  = fill_v_i ? fill_addr_i[3 +: idx_w] : s2_addr[3 +: idx_w];
  assign wr_tag  = fill_v_i ? fill_addr_i[dcache_pkg::PADDR_WIDTH-1 -: tag_w]
                            : s2_addr[dcache_pkg::PADDR_WIDTH-1 -: tag_w];
  assign wr_data = fill_v_i ? fill_data_i : s2_store_line;

  assign miss_v_o    = miss_pending_r & ~miss_sent_r;
  assign miss_addr_o = miss_addr_r;

  always_ff @(posedge clk_i)
  begin
    if (replay_o && !s2_is_store)
      miss_addr_r <= s2_addr;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      s1_v           <= 1'b0;
      s2_v           <= 1'b0;
      miss_pending_r <= 1'b0;
      miss_sent_r    <= 1'b0;
    end
    else
    begin
      // Replay squashes both younger stages
      s1_v <= issue_yumi_o;
      s2_v <= s1_v & ~replay_o;
      if (fill_v_i)
      begin
        miss_pending_r <= 1'b0;
        miss_sent_r    <= 1'b0;
      end
      else
      begin
        if (replay_o && !s2_is_store)
          miss_pending_r <= 1'b1;
        if (miss_v_o && miss_ready_i)
          miss_sent_r <= 1'b1;
      end
    end
  end

endmodule

/* src/miss_engine.sv */
// Store buffer drains as memory writes; a miss waits for it to empty before the read
// Exactly one memory response is expected per read, none for writes

`timescale 1ns/1ps

module miss_engine
  #(parameter int store_buf_els_p = 2)
  (input  logic                       clk_i
  ,input  logic                       rst_n_i

  ,input  logic                       miss_v_i
  ,output logic                       miss_ready_o
  ,input  dcache_pkg::paddr_t         miss_addr_i

  ,input  logic                       store_v_i
  ,output logic                       store_ready_o
  ,input  dcache_pkg::paddr_t         store_addr_i
  ,input  dcache_pkg::dword_t         store_data_i
  ,input  dcache_pkg::strb_t          store_strb_i

  ,output logic                       fill_v_o
  ,output dcache_pkg::paddr_t         fill_addr_o
  ,output dcache_pkg::dword_t         fill_data_o

  ,output logic                       mem_cmd_v_o
  ,input  logic                       mem_cmd_ready_i
  ,output dcache_pkg::mem_op_e        mem_cmd_op_o
  ,output dcache_pkg::paddr_t         mem_cmd_addr_o
  ,output dcache_pkg::dword_t         mem_cmd_data_o
  ,output dcache_pkg::strb_t          mem_cmd_strb_o

  ,input  logic                       mem_resp_v_i
  ,output logic                       mem_resp_ready_o
  ,input  dcache_pkg::dword_t         mem_resp_data_i
  );

  localparam int ptr_w = (store_buf_els_p > 1) ? $clog2(store_buf_els_p) : 1;
  localparam int cnt_w = $clog2(store_buf_els_p + 1);

  dcache_pkg::paddr_t  sb_addr [store_buf_els_p];
  dcache_pkg::dword_t  sb_data [store_buf_els_p];
  dcache_pkg::strb_t   sb_strb [store_buf_els_p];

  logic [ptr_w-1:0]    sb_wr_ptr_r;
  logic [ptr_w-1:0]    sb_rd_ptr_r;
  logic [cnt_w-1:0]    sb_cnt_r;
  logic                sb_push;
  logic                sb_pop;
  logic                sb_empty;

  dcache_pkg::engine_state_e state_r;
  dcache_pkg::paddr_t        miss_addr_r;
  logic                      rd_sel;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(store_buf_els_p - 1))
      return '0;
    else
      return ptr + 1'b1;
  endfunction

  assign sb_empty      = (sb_cnt_r == '0);
  assign store_ready_o = (sb_cnt_r != cnt_w'(store_buf_els_p));
  assign sb_push       = store_v_i & store_ready_o;

  // Read owns the command channel only in e_read, otherwise the buffer head
  assign rd_sel         = (state_r == dcache_pkg::e_read);
  assign mem_cmd_v_o    = rd_sel | ~sb_empty;
  assign mem_cmd_op_o   = rd_sel ? dcache_pkg::e_mem_rd : dcache_pkg::e_mem_wr;
  assign mem_cmd_addr_o = rd_sel ? {miss_addr_r[dcache_pkg::PADDR_WIDTH-1:3], 3'b000}
                                 : sb_addr[sb_rd_ptr_r];
  assign mem_cmd_data_o = rd_sel ? '0 : sb_data[sb_rd_ptr_r];
  assign mem_cmd_strb_o = rd_sel ? '1 : sb_strb[sb_rd_ptr_r];
  assign sb_pop         = ~rd_sel & ~sb_empty & mem_cmd_ready_i;

  assign miss_ready_o     = (state_r == dcache_pkg::e_idle);
  assign mem_resp_ready_o = (state_r == dcache_pkg::e_wait);

  assign fill_v_o    = mem_resp_ready_o & mem_resp_v_i;
  assign fill_addr_o = miss_addr_r;
  assign fill_data_o = mem_resp_data_i;

  always_ff @(posedge clk_i)
  begin
    if (sb_push)
    begin
      sb_addr[sb_wr_ptr_r] <= store_addr_i;
      sb_data[sb_wr_ptr_r] <= store_data_i;
      sb_strb[sb_wr_ptr_r] <= store_strb_i;
    end
    if (miss_v_i && miss_ready_o)
      miss_addr_r <= miss_addr_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sb_wr_ptr_r <= '0;
      sb_rd_ptr_r <= '0;
      sb_cnt_r    <= '0;
      state_r     <= dcache_pkg::e_idle;
    end
    else
    begin
      if (sb_push)
        sb_wr_ptr_r <= next_ptr(sb_wr_ptr_r);
      if (sb_pop)
        sb_rd_ptr_r <= next_ptr(sb_rd_ptr_r);
      sb_cnt_r <= sb_cnt_r + cnt_w'(sb_push) - cnt_w'(sb_pop);

      case (state_r)
        dcache_pkg::e_idle:
          if (miss_v_i)
            state_r <= dcache_pkg::e_drain;
        // Memory must see every older store before the line is read
        dcache_pkg::e_drain:
          if (sb_empty)
            state_r <= dcache_pkg::e_read;
        dcache_pkg::e_read:
          if (mem_cmd_ready_i)
            state_r <= dcache_pkg::e_wait;
        default:
          if (mem_resp_v_i)
            state_r <= dcache_pkg::e_idle;
      endcase
    end
  end

endmodule

/* src/dcache_top.sv */
// Replay queue in front of a blocking write-through data cache
// Responses come back in request order with no back-pressure

`timescale 1ns/1ps

module dcache_top
  #(parameter int sets_p          = 16
  ,parameter int queue_els_p     = 8
  ,parameter int store_buf_els_p = 2
  )
  (input  logic                    clk_i
  ,input  logic                    rst_n_i

  ,input  logic                    req_v_i
  ,output logic                    req_ready_o
  ,input  dcache_pkg::dcache_op_e  req_op_i
  ,input  dcache_pkg::paddr_t      req_addr_i
  ,input  dcache_pkg::dword_t      req_data_i

  ,output logic                    resp_v_o
  ,output dcache_pkg::dword_t      resp_data_o

  ,output logic                    mem_cmd_v_o
  ,input  logic                    mem_cmd_ready_i
  ,output dcache_pkg::mem_op_e     mem_cmd_op_o
  ,output dcache_pkg::paddr_t      mem_cmd_addr_o
  ,output dcache_pkg::dword_t      mem_cmd_data_o
  ,output dcache_pkg::strb_t       mem_cmd_strb_o

  ,input  logic                    mem_resp_v_i
  ,output logic                    mem_resp_ready_o
  ,input  dcache_pkg::dword_t      mem_resp_data_i
  );

  logic                   issue_v, issue_yumi, commit, replay;
  dcache_pkg::dcache_op_e issue_op;
  dcache_pkg::paddr_t     issue_addr;
  dcache_pkg::dword_t     issue_data;

  logic                   miss_v, miss_ready;
  dcache_pkg::paddr_t     miss_addr;

  logic                   store_v, store_ready;
  dcache_pkg::paddr_t     store_addr;
  dcache_pkg::dword_t     store_data;
  dcache_pkg::strb_t      store_strb;

  logic                   fill_v;
  dcache_pkg::paddr_t     fill_addr;
  dcache_pkg::dword_t     fill_data;

  replay_queue
   #(.queue_els_p(queue_els_p))
   i_replay_queue
   (.clk_i(clk_i)
   ,.rst_n_i(rst_n_i)
   ,.enq_v_i(req_v_i)
   ,.enq_op_i(req_op_i)
   ,.enq_addr_i(req_addr_i)
   ,.enq_data_i(req_data_i)
   ,.enq_ready_o(req_ready_o)
   ,.issue_v_o(issue_v)
   ,.issue_op_o(issue_op)
   ,.issue_addr_o(issue_addr)
   ,.issue_data_o(issue_data)
   ,.issue_yumi_i(issue_yumi)
   ,.commit_i(commit)
   ,.replay_i(replay)
   );

  dcache_pipe
   #(.sets_p(sets_p))
   i_dcache_pipe
   (.clk_i(clk_i)
   ,.rst_n_i(rst_n_i)
   ,.issue_v_i(issue_v)
   ,.issue_op_i(issue_op)
   ,.issue_addr_i(issue_addr)
   ,.issue_data_i(issue_data)
   ,.issue_yumi_o(issue_yumi)
   ,.commit_o(commit)
   ,.replay_o(replay)
   ,.resp_v_o(resp_v_o)
   ,.resp_data_o(resp_data_o)
   ,.miss_v_o(miss_v)
   ,.miss_ready_i(miss_ready)
   ,.miss_addr_o(miss_addr)
   ,.store_v_o(store_v)
   ,.store_ready_i(store_ready)
   ,.store_addr_o(store_addr)
   ,.store_data_o(store_data)
   ,.store_strb_o(store_strb)
   ,.fill_v_i(fill_v)
   ,.fill_addr_i(fill_addr)
   ,.fill_data_i(fill_data)
   );

  miss_engine
   #(.store_buf_els_p(store_buf_els_p))
   i_miss_engine
   (.clk_i(clk_i)
   ,.rst_n_i(rst_n_i)
   ,.miss_v_i(miss_v)
   ,.miss_ready_o(miss_ready)
   ,.miss_addr_i(miss_addr)
   ,.store_v_i(store_v)
   ,.store_ready_o(store_ready)
   ,.store_addr_i(store_addr)
   ,.store_data_i(store_data)
   ,.store_strb_i(store_strb)
   ,.fill_v_o(fill_v)
   ,.fill_addr_o(fill_addr)
   ,.fill_data_o(fill_data)
   ,.mem_cmd_v_o(mem_cmd_v_o)
   ,.mem_cmd_ready_i(mem_cmd_ready_i)
   ,.mem_cmd_op_o(mem_cmd_op_o)
   ,.mem_cmd_addr_o(mem_cmd_addr_o)
   ,.mem_cmd_data_o(mem_cmd_data_o)
   ,.mem_cmd_strb_o(mem_cmd_strb_o)
   ,.mem_resp_v_i(mem_resp_v_i)
   ,.mem_resp_ready_o(mem_resp_ready_o)
   ,.mem_resp_data_i(mem_resp_data_i)
   );

endmodule

/* verification/dcache_chk.sv */
// Port-level checks that need no memory model, sampled on the rising clock
// Bound into every dcache_top instance

`timescale 1ns/1ps

module dcache_chk
  (input logic                 clk_i
  ,input logic                 rst_n_i
  ,input logic                 req_ready_i
  ,input logic                 resp_v_i
  ,input logic                 mem_cmd_v_i
  ,input logic                 mem_cmd_ready_i
  ,input dcache_pkg::mem_op_e  mem_cmd_op_i
  ,input dcache_pkg::paddr_t   mem_cmd_addr_i
  ,input dcache_pkg::dword_t   mem_cmd_data_i
  ,input dcache_pkg::strb_t    mem_cmd_strb_i
  ,input logic                 mem_resp_ready_i
  );

  int unsigned fail_cnt = 0;

  // Idle outputs on the first edge out of reset
  reset_idle: assert property (@(posedge clk_i) $rose(rst_n_i)
      |-> req_ready_i && !resp_v_i && !mem_cmd_v_i && !mem_resp_ready_i)
  else
  begin
    fail_cnt++;
    $error("Top-level outputs were not idle when reset was released");
  end

  // A stalled memory command keeps its valid and payload
  cmd_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_cmd_v_i && !mem_cmd_ready_i
      |=> mem_cmd_v_i && $stable(mem_cmd_op_i) && $stable(mem_cmd_addr_i)
          && $stable(mem_cmd_data_i) && $stable(mem_cmd_strb_i))
  else
  begin
    fail_cnt++;
    $error("Memory command changed or dropped before it was accepted");
  end

endmodule

bind dcache_top dcache_chk i_dcache_chk
  (.clk_i(clk_i)
  ,.rst_n_i(rst_n_i)
  ,.req_ready_i(req_ready_o)
  ,.resp_v_i(resp_v_o)
  ,.mem_cmd_v_i(mem_cmd_v_o)
  ,.mem_cmd_ready_i(mem_cmd_ready_i)
  ,.mem_cmd_op_i(mem_cmd_op_o)
  ,.mem_cmd_addr_i(mem_cmd_addr_o)
  ,.mem_cmd_data_i(mem_cmd_data_o)
  ,.mem_cmd_strb_i(mem_cmd_strb_o)
  ,.mem_resp_ready_i(mem_resp_ready_o)
  );

/* verification/tb_dcache.sv */
// Directed and random traffic against a memory model with a 1 to 4 cycle read delay
// Expected responses and writes come from a shadow updated in request order

`timescale 1ns/1ps

module tb_dcache;

  localparam int n_bp_lp     = 20;
  localparam int n_random_lp = 260;
  // About 14 cycles per request when loads miss behind a stalled store buffer
  localparam int max_cycles_lp = (n_bp_lp + n_random_lp + 6) * 14;
  localparam dcache_pkg::paddr_t line_a_lp = 16'h1230;

  logic                   clk;
  logic                   rst_n;
  logic                   req_v;
  logic                   req_ready;
  dcache_pkg::dcache_op_e req_op;
  dcache_pkg::paddr_t     req_addr;
  dcache_pkg::dword_t     req_data;
  logic                   resp_v;
  dcache_pkg::dword_t     resp_data;
  logic                   mem_cmd_v;
  logic                   mem_cmd_ready;
  dcache_pkg::mem_op_e    mem_cmd_op;
  dcache_pkg::paddr_t     mem_cmd_addr;
  dcache_pkg::dword_t     mem_cmd_data;
  dcache_pkg::strb_t      mem_cmd_strb;
  logic                   mem_resp_v;
  logic                   mem_resp_ready;
  dcache_pkg::dword_t     mem_resp_data;

  // Shadows indexed by doubleword; one follows memory writes, one follows requests
  dcache_pkg::dword_t mem_shadow [8192];
  dcache_pkg::dword_t req_shadow [8192];

  dcache_pkg::dword_t exp_q     [$];
  dcache_pkg::paddr_t wr_addr_q [$];
  dcache_pkg::dword_t wr_data_q [$];
  dcache_pkg::strb_t  wr_strb_q [$];
  dcache_pkg::dword_t rd_q      [$];

  logic               ready_pat [1024];
  int                 delay_pat [256];
  logic [1:0]         cmd_mode;
  logic               saw_full;
  int                 seed;
  int                 cycle_cnt = 0;
  int                 err_cnt = 0;
  int                 acc_cnt = 0;
  int                 resp_cnt = 0;
  int                 rd_cnt = 0;
  int                 rd_served = 0;
  int                 acc_cycle;
  int                 resp_cycle;
  int                 rd_before;
  int                 total_err;
  int                 k;
  int                 w;
  dcache_pkg::paddr_t last_rd_addr;
  dcache_pkg::dword_t exp_data;
  dcache_pkg::dword_t mask;
  dcache_pkg::dword_t cur_line;
  logic [31:0]        cur_word;

  dcache_top
   #(.sets_p(16)
    ,.queue_els_p(8)
    ,.store_buf_els_p(2)
    )
   i_dcache_top
   (.clk_i(clk)
   ,.rst_n_i(rst_n)
   ,.req_v_i(req_v)
   ,.req_ready_o(req_ready)
   ,.req_op_i(req_op)
   ,.req_addr_i(req_addr)
   ,.req_data_i(req_data)
   ,.resp_v_o(resp_v)
   ,.resp_data_o(resp_data)
   ,.mem_cmd_v_o(mem_cmd_v)
   ,.mem_cmd_ready_i(mem_cmd_ready)
   ,.mem_cmd_op_o(mem_cmd_op)
   ,.mem_cmd_addr_o(mem_cmd_addr)
   ,.mem_cmd_data_o(mem_cmd_data)
   ,.mem_cmd_strb_o(mem_cmd_strb)
   ,.mem_resp_v_i(mem_resp_v)
   ,.mem_resp_ready_o(mem_resp_ready)
   ,.mem_resp_data_i(mem_resp_data)
   );

  // Doubleword at byte address a starts as a repeated four times
  function automatic dcache_pkg::dword_t init_line(input int idx);
    logic [15:0] a;
    a = 16'(idx * 8);
    return {4{a}};
  endfunction

  function automatic dcache_pkg::dword_t strb_mask(input dcache_pkg::strb_t strb);
    dcache_pkg::dword_t m;
    for (int i = 0; i < 8; i++)
      m[8*i +: 8] = {8{strb[i]}};
    return m;
  endfunction

  task automatic send_req(input dcache_pkg::dcache_op_e op, input dcache_pkg::paddr_t addr,
                          input dcache_pkg::dword_t data);
    req_v    = 1'b1;
    req_op   = op;
    req_addr = addr;
    req_data = data;
    @(posedge clk);
    while (!req_ready)
      @(posedge clk);
    #1;
    req_v = 1'b0;
  endtask

  task automatic send_random();
    dcache_pkg::dcache_op_e op;
    dcache_pkg::paddr_t     addr;
    dcache_pkg::dword_t     data;
    op   = dcache_pkg::dcache_op_e'(2'($random(seed)));
    addr = 16'h7f80 + 16'(($unsigned($random(seed)) % 32) * 8);
    if (op == dcache_pkg::e_op_lw || op == dcache_pkg::e_op_sw)
      addr[2] = 1'($random(seed));
    data = {$random(seed), $random(seed)};
    send_req(op, addr, data);
  endtask

  task automatic wait_responses();
    while (exp_q.size() != 0)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial
  begin
    repeat (max_cycles_lp) @(posedge clk);
    $display("Timeout after %0d cycles, %0d responses and %0d writes still expected, %0d errors",
             max_cycles_lp, exp_q.size(), wr_addr_q.size(), err_cnt);
    $display("*** TEST FAILED ***");
    $finish;
  end

  always @(posedge clk)
  begin
    #1;
    case (cmd_mode)
      2'd0: mem_cmd_ready = 1'b1;
      2'd1: mem_cmd_ready = 1'b0;
      default: mem_cmd_ready = ready_pat[cycle_cnt % 1024];
    endcase
  end

  // Memory read responses, one per read command
  initial
  begin
    mem_resp_v    = 1'b0;
    mem_resp_data = '0;
    forever
    begin
      @(posedge clk);
      #1;
      if (rd_q.size() != 0)
      begin
        repeat (delay_pat[rd_served % 256] - 1)
        begin
          @(posedge clk);
          #1;
        end
        mem_resp_v    = 1'b1;
        mem_resp_data = rd_q.pop_front();
        rd_served++;
        @(posedge clk);
        while (!mem_resp_ready)
          @(posedge clk);
        #1;
        mem_resp_v = 1'b0;
      end
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (req_v && req_ready)
    begin
      acc_cnt++;
      acc_cycle = cycle_cnt;
      cur_line  = req_shadow[req_addr[15:3]];
      cur_word  = req_addr[2] ? cur_line[63:32] : cur_line[31:0];
      case (req_op)
        dcache_pkg::e_op_ld:
          exp_q.push_back(cur_line);
        dcache_pkg::e_op_lw:
          exp_q.push_back({{32{cur_word[31]}}, cur_word});
        dcache_pkg::e_op_sd:
        begin
          req_shadow[req_addr[15:3]] = req_data;
          exp_q.push_back('0);
          wr_addr_q.push_back(req_addr);
          wr_data_q.push_back(req_data);
          wr_strb_q.push_back(8'hff);
        end
        default:
        begin
          if (req_addr[2])
            cur_line[63:32] = req_data[31:0];
          else
            cur_line[31:0] = req_data[31:0];
          req_shadow[req_addr[15:3]] = cur_line;
          exp_q.push_back('0);
          wr_addr_q.push_back(req_addr);
          wr_data_q.push_back(cur_line);
          wr_strb_q.push_back(req_addr[2] ? 8'hf0 : 8'h0f);
        end
      endcase
    end

    if (resp_v)
    begin
      resp_cnt++;
      resp_cycle = cycle_cnt;
      resp_expected: assert (exp_q.size() != 0)
      else
      begin
        err_cnt++;
        $display("Response arrived with no accepted request outstanding");
      end
      if (exp_q.size() != 0)
      begin
        exp_data = exp_q.pop_front();
        resp_match: assert (resp_data === exp_data)
        else
        begin
          err_cnt++;
          $display("FAIL resp_data_o got %h expected %h", resp_data, exp_data);
        end
      end
    end

    if (mem_cmd_v && mem_cmd_ready)
    begin
      if (mem_cmd_op == dcache_pkg::e_mem_wr)
      begin
        wr_expected: assert (wr_addr_q.size() != 0)
        else
        begin
          err_cnt++;
          $display("Memory write issued with no store outstanding");
        end
        if (wr_addr_q.size() != 0)
        begin
          mask = strb_mask(wr_strb_q[0]);
          wr_addr_match: assert (mem_cmd_addr === wr_addr_q[0])
          else
          begin
            err_cnt++;
            $display("FAIL mem_cmd_addr_o got %h expected %h", mem_cmd_addr, wr_addr_q[0]);
          end
          wr_strb_match: assert (mem_cmd_strb === wr_strb_q[0])
          else
          begin
            err_cnt++;
            $display("FAIL mem_cmd_strb_o got %h expected %h", mem_cmd_strb, wr_strb_q[0]);
          end
          wr_data_match: assert ((mem_cmd_data & mask) === (wr_data_q[0] & mask))
          else
          begin
            err_cnt++;
            $display("FAIL mem_cmd_data_o got %h expected %h", mem_cmd_data & mask,
                     wr_data_q[0] & mask);
          end
          void'(wr_addr_q.pop_front());
          void'(wr_data_q.pop_front());
          void'(wr_strb_q.pop_front());
        end
        mask = strb_mask(mem_cmd_strb);
        mem_shadow[mem_cmd_addr[15:3]] = (mem_shadow[mem_cmd_addr[15:3]] & ~mask)
                                       | (mem_cmd_data & mask);
      end
      else
      begin
        rd_cnt++;
        last_rd_addr = mem_cmd_addr;
        rd_q.push_back(mem_shadow[mem_cmd_addr[15:3]]);
      end
    end
  end

  initial
  begin
    rst_n         = 1'b0;
    req_v         = 1'b0;
    req_op        = dcache_pkg::e_op_ld;
    req_addr      = '0;
    req_data      = '0;
    mem_cmd_ready = 1'b1;
    cmd_mode      = 2'd0;
    saw_full      = 1'b0;
    seed          = 34;
    for (int i = 0; i < 8192; i++)
    begin
      mem_shadow[i] = init_line(i);
      req_shadow[i] = init_line(i);
    end
    for (int i = 0; i < 1024; i++)
      ready_pat[i] = ($unsigned($random(seed)) % 3) != 0;
    for (int i = 0; i < 256; i++)
      delay_pat[i] = 1 + $unsigned($random(seed)) % 4;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (2) @(posedge clk);
    #1;

    // Cold line reads memory once, the repeat hits
    rd_before = rd_cnt;
    send_req(dcache_pkg::e_op_ld, line_a_lp, '0);
    wait_responses();
    cold_read: assert (rd_cnt == rd_before + 1 && last_rd_addr == line_a_lp)
    else
    begin
      err_cnt++;
      $display("Load to a cold line did not read that line from memory exactly once");
    end
    rd_before = rd_cnt;
    send_req(dcache_pkg::e_op_ld, line_a_lp, '0);
    wait_responses();
    warm_no_read: assert (rd_cnt == rd_before)
    else
    begin
      err_cnt++;
      $display("Load to a filled line read memory again");
    end

    send_req(dcache_pkg::e_op_ld, line_a_lp, '0);
    wait_responses();
    hit_latency: assert (resp_cycle - acc_cycle == 3)
    else
    begin
      err_cnt++;
      $display("FAIL resp_v_o latency got %h expected %h", resp_cycle - acc_cycle, 3);
    end

    // Upper word store, then both halves read back
    send_req(dcache_pkg::e_op_sw, line_a_lp + 16'h4, 64'h0123_4567_89ab_cdef);
    send_req(dcache_pkg::e_op_lw, line_a_lp + 16'h4, '0);
    send_req(dcache_pkg::e_op_ld, line_a_lp, '0);
    wait_responses();

    // Memory commands held off until the request queue backs up
    @(posedge clk);
    cmd_mode = 2'd1;
    #1;
    fork
      begin
        for (k = 0; k < n_bp_lp; k++)
          send_req(dcache_pkg::e_op_sd, 16'h7f80 + 16'(k * 8), {$random(seed), $random(seed)});
      end
      begin
        w = 0;
        @(posedge clk);
        while (req_ready && w < 200)
        begin
          w++;
          @(posedge clk);
        end
        saw_full = !req_ready;
        cmd_mode = 2'd2;
      end
    join
    queue_backed_up: assert (saw_full)
    else
    begin
      err_cnt++;
      $display("req_ready_o never dropped while memory commands were held off");
    end

    for (k = 0; k < n_random_lp; k++)
    begin
      if (k == n_random_lp / 2)
      begin
        @(posedge clk);
        cmd_mode = 2'd0;
        #1;
      end
      send_random();
    end
    while (exp_q.size() != 0 || wr_addr_q.size() != 0 || rd_q.size() != 0)
    begin
      @(posedge clk);
      #1;
    end
    repeat (5) @(posedge clk);
    all_responses: assert (resp_cnt == acc_cnt)
    else
    begin
      err_cnt++;
      $display("FAIL resp_v_o count got %h expected %h", resp_cnt, acc_cnt);
    end

    total_err = err_cnt + i_dcache_top.i_dcache_chk.fail_cnt;
    $display("Requests %0d, responses %0d, reads %0d, testbench errors %0d, assertion errors %0d",
             acc_cnt, resp_cnt, rd_cnt, err_cnt, i_dcache_top.i_dcache_chk.fail_cnt);
    if (total_err == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

/* dcache_replay.f */
src/dcache_pkg.sv
src/replay_queue.sv
src/dcache_pipe.sv
src/miss_engine.sv
src/dcache_top.sv
verification/dcache_chk.sv
verification/tb_dcache.sv
